// ==== list.f ====
+incdir+hw
hw/sdram_pkg.sv
hw/slot_pkg.sv
hw/ram_rq.sv
hw/rom_rq.sv
hw/sdram_arbiter.sv
hw/sdram_mem.sv
hw/sdram_sub.sv
dv/sdram_sub_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module sdram_sub_tb -o sim_sdram_sub
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_sdram_sub)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench printed its pass line
if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== dv/sdram_sub_tb.sv ====
`timescale 1ns/1ps
`include "sdram_settings.svh"

// directed testbench for the two-slot sdram subsystem
module sdram_sub_tb;
    import slot_pkg::*;

    localparam int ACCESSES   = 53;                   // slot accesses over all tests
    localparam int MAX_CYCLES = 40 * ACCESSES + 100;  // reset and idle gaps in the margin
    localparam int MEM_WORDS  = 1 << `MEM_AW;

    logic               clk = 1'b0;
    logic               rst;
    slot_offset_t       ram_offset;
    logic [`RAM_AW-1:0] ram_addr;
    logic               ram_addr_ok;
    logic               ram_wrin;
    ram_data_t          ram_wrdata;
    logic               ram_data_ok;
    ram_data_t          ram_dout;
    slot_offset_t       rom_offset;
    logic [`ROM_AW-1:0] rom_addr;
    logic               rom_addr_ok;
    logic               rom_data_ok;
    rom_data_t          rom_dout;

    logic [31:0] model [0:MEM_WORDS-1];   // expected memory words, only written ones are read
    logic [31:0] rng = 32'd69818;         // xorshift state
    int          cycle_cnt = 0;
    int          checks = 0;
    int          errors = 0;

    sdram_sub i_dut (
        .clk, .rst, .ram_offset, .ram_addr, .ram_addr_ok, .ram_wrin, .ram_wrdata,
        .ram_data_ok, .ram_dout, .rom_offset, .rom_addr, .rom_addr_ok, .rom_data_ok,
        .rom_dout
    );

    always #2 clk = ~clk;   // 4 ns period

    // hang guard
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // low MEM_AW bits of offset + word pick the memory word
    function automatic logic [`MEM_AW-1:0] word_index(input slot_offset_t base,
                                                     input slot_offset_t word);
        slot_offset_t sum;
        sum = base + word;
        return sum[`MEM_AW-1:0];
    endfunction

    // half-word address: upper bits give the word, bit 0 the half
    function automatic rom_data_t rom_expect(input logic [`ROM_AW-1:0] half_addr);
        logic [31:0] w;
        w = model[word_index(rom_offset, slot_offset_t'(half_addr >> 1))];
        return half_addr[0] ? w[31:16] : w[15:0];
    endfunction

    task automatic check_ram(input ram_data_t got, input ram_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rom(input rom_data_t got, input rom_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0d cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one ram slot access, cycles counted from the addr_ok edge to data_ok
    task automatic ram_access(input logic [`RAM_AW-1:0] a, input logic we, input ram_data_t d,
                              output ram_data_t q, output int cycles);
        @(posedge clk);
        ram_addr    <= a;
        ram_wrin    <= we;
        ram_wrdata  <= d;
        ram_addr_ok <= 1'b1;
        cycles = 0;
        @(negedge clk);         // outputs settled mid cycle
        while (!ram_data_ok) begin
            @(negedge clk);
            cycles++;
        end
        q = ram_dout;
        if (we) model[word_index(ram_offset, slot_offset_t'(a))] = 32'(d);   // zero extended
        @(posedge clk);
        ram_addr_ok <= 1'b0;
        do begin
            @(negedge clk);
        end while (ram_data_ok);
    endtask

    task automatic rom_read(input logic [`ROM_AW-1:0] a, output rom_data_t q,
                            output int cycles);
        @(posedge clk);
        rom_addr    <= a;
        rom_addr_ok <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!rom_data_ok) begin
            @(negedge clk);
            cycles++;
        end
        q = rom_dout;
        @(posedge clk);
        rom_addr_ok <= 1'b0;
        do begin
            @(negedge clk);
        end while (rom_data_ok);
    endtask

    // write then read back, random address and data
    task automatic ram_write_read_random();
        logic [31:0]        r;
        logic [`RAM_AW-1:0] a;
        ram_data_t          q;
        int                 cyc;
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            a = r[`RAM_AW-1:0];
            ram_access(a, 1'b1, r[31:24], q, cyc);
            ram_access(a, 1'b0, '0, q, cyc);
            check_ram(q, ram_data_t'(model[word_index(ram_offset, slot_offset_t'(a))]),
                      "ram read after write");
        end
    endtask

    // ram region moved by 0x100 words, seen through the rom slot at offset 0
    task automatic ram_offset_via_rom();
        logic [31:0]        r;
        logic [`RAM_AW-1:0] a [0:3];
        ram_data_t          d [0:3];
        ram_data_t          q;
        rom_data_t          h;
        logic [`ROM_AW-1:0] ha;
        int                 cyc;
        @(posedge clk);
        ram_offset <= 22'h100;
        rom_offset <= '0;
        for (int k = 0; k < 4; k++) begin
            r    = next_rand();
            a[k] = `RAM_AW'(k * 64) + `RAM_AW'(r[5:0]);   // distinct words, no stale cache
            d[k] = r[15:8];
            ram_access(a[k], 1'b1, d[k], q, cyc);
        end
        for (int k = 0; k < 4; k++) begin
            ha = `ROM_AW'((slot_offset_t'(22'h100) + slot_offset_t'(a[k])) << 1);
            rom_read(ha, h, cyc);
            check_rom(h, rom_data_t'(d[k]), "rom low half of an offset ram word");
            rom_read(ha | `ROM_AW'(1), h, cyc);
            check_rom(h, '0, "rom high half of an offset ram word");
        end
        @(posedge clk);
        ram_offset <= '0;
    endtask

    // second half of the same word comes from the cache
    task automatic rom_halves_and_cache();
        logic [31:0] r;
        ram_data_t   q;
        rom_data_t   h;
        int          cyc;
        int          miss_cyc;
        int          hit_cyc;
        r = next_rand();
        ram_access(`RAM_AW'('h300), 1'b1, r[7:0], q, cyc);
        rom_read(`ROM_AW'('h600), h, miss_cyc);
        check_rom(h, rom_expect(`ROM_AW'('h600)), "rom low half, cache miss");
        rom_read(`ROM_AW'('h601), h, hit_cyc);
        check_rom(h, rom_expect(`ROM_AW'('h601)), "rom high half, cache hit");
        check_flag(hit_cyc < miss_cyc, 1'b1, "cache hit faster than miss");
    endtask

    // both slots start in the same cycle, ram has priority
    task automatic slot_contention();
        logic [31:0] r;
        ram_data_t   q;
        int          cyc;
        int          n;
        int          ram_cyc;
        int          rom_cyc;
        r = next_rand();
        ram_access(`RAM_AW'('h310), 1'b1, r[7:0], q, cyc);     // rom target
        ram_access(`RAM_AW'('h320), 1'b1, r[23:16], q, cyc);   // ram target
        @(posedge clk);
        ram_addr    <= `RAM_AW'('h320);
        ram_wrin    <= 1'b0;
        ram_addr_ok <= 1'b1;
        rom_addr    <= `ROM_AW'('h620);
        rom_addr_ok <= 1'b1;
        n       = 0;
        ram_cyc = 0;
        rom_cyc = 0;
        while (ram_cyc == 0 || rom_cyc == 0) begin
            @(negedge clk);
            n++;
            if (ram_data_ok && ram_cyc == 0) ram_cyc = n;
            if (rom_data_ok && rom_cyc == 0) rom_cyc = n;
        end
        check_ram(ram_dout, ram_data_t'(model['h320]), "ram read under contention");
        check_rom(rom_dout, rom_expect(`ROM_AW'('h620)), "rom read under contention");
        check_flag(ram_cyc < rom_cyc, 1'b1, "ram data_ok before rom data_ok");
        @(posedge clk);
        ram_addr_ok <= 1'b0;
        rom_addr_ok <= 1'b0;
        while (ram_data_ok || rom_data_ok) @(negedge clk);
    endtask

    // uncontended latency and the data_ok hold rule
    task automatic data_ok_hold_and_latency();
        logic [31:0] r;
        ram_data_t   q;
        int          cyc;
        r = next_rand();
        ram_access(`RAM_AW'('h055), 1'b1, r[7:0], q, cyc);
        @(posedge clk);
        ram_addr    <= `RAM_AW'('h055);
        ram_wrin    <= 1'b0;
        ram_addr_ok <= 1'b1;
        cyc = 0;
        @(negedge clk);         // still in the cycle of the addr_ok edge
        while (!ram_data_ok) begin
            @(negedge clk);
            cyc++;
        end
        check_cycles(cyc, `MEM_LAT + 3, "ram read latency without contention");
        check_ram(ram_dout, ram_data_t'(model['h055]), "ram read in latency test");
        repeat (3) begin
            @(negedge clk);
            check_flag(ram_data_ok, 1'b1, "data_ok held while addr_ok high");
        end
        @(posedge clk);
        ram_addr_ok <= 1'b0;
        @(negedge clk);         // slot sees the fall on the next edge
        @(negedge clk);
        check_flag(ram_data_ok, 1'b0, "data_ok low the cycle after addr_ok drops");
    endtask

    initial begin
        rst         = 1'b1;
        ram_offset  = '0;
        ram_addr    = '0;
        ram_addr_ok = 1'b0;
        ram_wrin    = 1'b0;
        ram_wrdata  = '0;
        rom_offset  = '0;
        rom_addr    = '0;
        rom_addr_ok = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        ram_write_read_random();
        ram_offset_via_rom();
        rom_halves_and_cache();
        slot_contention();
        data_ok_hold_and_latency();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== hw/sdram_sub.sv ====
`timescale 1ns/1ps
`include "sdram_settings.svh"

// two client slots sharing one memory through the arbiter
module sdram_sub (
    input  logic                   clk,
    input  logic                   rst,
    // ram slot, read/write
    input  slot_pkg::slot_offset_t ram_offset,
    input  logic [`RAM_AW-1:0]     ram_addr,
    input  logic                   ram_addr_ok,
    input  logic                   ram_wrin,
    input  slot_pkg::ram_data_t    ram_wrdata,
    output logic                   ram_data_ok,
    output slot_pkg::ram_data_t    ram_dout,
    // rom slot, read only
    input  slot_pkg::slot_offset_t rom_offset,
    input  logic [`ROM_AW-1:0]     rom_addr,
    input  logic                   rom_addr_ok,
    output logic                   rom_data_ok,
    output slot_pkg::rom_data_t    rom_dout
);
    import sdram_pkg::*;

    logic        ram_req, ram_rnw, ram_ack, ram_din_ok;
    sdram_addr_t ram_sdram_addr;
    sdram_word_t ram_wdata;
    logic        rom_req, rom_ack, rom_din_ok;
    sdram_addr_t rom_sdram_addr;
    sdram_word_t arb_rdata;         // shared return data
    logic        cmd_valid, cmd_we, done;
    sdram_addr_t cmd_addr;
    sdram_word_t cmd_wdata, mem_rdata;

    ram_rq i_ram (
        .clk, .rst, .addr(ram_addr), .offset(ram_offset), .addr_ok(ram_addr_ok),
        .wrin(ram_wrin), .wrdata(ram_wrdata), .ack(ram_ack), .din_ok(ram_din_ok),
        .din(arb_rdata), .req(ram_req), .req_rnw(ram_rnw),
        .sdram_addr(ram_sdram_addr), .wdata(ram_wdata), .data_ok(ram_data_ok),
        .dout(ram_dout)
    );

    rom_rq i_rom (
        .clk, .rst, .addr(rom_addr), .offset(rom_offset), .addr_ok(rom_addr_ok),
        .ack(rom_ack), .din_ok(rom_din_ok), .din(arb_rdata), .req(rom_req),
        .sdram_addr(rom_sdram_addr), .data_ok(rom_data_ok), .dout(rom_dout)
    );

    sdram_arbiter i_arb (
        .clk, .rst, .ram_req, .ram_rnw, .ram_addr(ram_sdram_addr), .ram_wdata,
        .rom_req, .rom_addr(rom_sdram_addr), .done, .mem_rdata, .ram_ack,
        .ram_din_ok, .rom_ack, .rom_din_ok, .rdata(arb_rdata), .cmd_valid,
        .cmd_we, .cmd_addr, .cmd_wdata
    );

    sdram_mem i_mem (
        .clk, .rst, .cmd_valid, .cmd_we, .cmd_addr, .cmd_wdata, .done,
        .rdata(mem_rdata)
    );

endmodule

// ==== hw/sdram_mem.sv ====
`timescale 1ns/1ps
`include "sdram_settings.svh"

// word memory with a fixed latency, in place of a real sdram controller
module sdram_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    input  logic                   cmd_we,
    input  sdram_pkg::sdram_addr_t cmd_addr,
    input  sdram_pkg::sdram_word_t cmd_wdata,
    output logic                   done,
    output sdram_pkg::sdram_word_t rdata
);
    import sdram_pkg::*;

    localparam int LAT = `MEM_LAT;
    localparam int CW  = $clog2(LAT + 1);

    sdram_word_t          mem [0:(1 << `MEM_AW) - 1];
    logic [CW-1:0]        cnt;        // cycles left before done
    logic [`MEM_AW-1:0]   cmd_idx;    // only the low bits select a word
    logic [`MEM_AW-1:0]   addr_q;
    logic [`MEM_AW-1:0]   rd_idx;
    logic                 last_tick;
    logic                 fire;       // raise done on this edge

    assign cmd_idx   = cmd_addr[`MEM_AW-1:0];
    assign last_tick = (cnt == CW'(1));
    // with a latency of one, done follows the command directly
    assign fire      = (cmd_valid && (LAT == 1)) || last_tick;
    assign rd_idx    = last_tick ? addr_q : cmd_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= fire;
            if (cmd_valid) cnt <= CW'(LAT - 1);
            else if (cnt != '0) cnt <= cnt - 1'b1;
        end
    end

    // array and read data
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            addr_q <= cmd_idx;
            if (cmd_we) mem[cmd_idx] <= cmd_wdata;  // write commits on accept
        end
        if (fire) rdata <= mem[rd_idx];             // read sampled with done
    end

    // the arbiter waits for done before the next command
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> (cnt == '0))
        else $error("sdram_mem: command while busy");

endmodule

// ==== hw/sdram_arbiter.sv ====
`timescale 1ns/1ps
`include "sdram_settings.svh"

// fixed priority arbiter, ram slot wins over rom slot
// one command in the memory at a time
module sdram_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ram_req,
    input  logic                   ram_rnw,
    input  sdram_pkg::sdram_addr_t ram_addr,
    input  sdram_pkg::sdram_word_t ram_wdata,
    input  logic                   rom_req,
    input  sdram_pkg::sdram_addr_t rom_addr,
    input  logic                   done,       // memory finished
    input  sdram_pkg::sdram_word_t mem_rdata,
    output logic                   ram_ack,
    output logic                   ram_din_ok,
    output logic                   rom_ack,
    output logic                   rom_din_ok,
    output sdram_pkg::sdram_word_t rdata,
    output logic                   cmd_valid,
    output logic                   cmd_we,
    output sdram_pkg::sdram_addr_t cmd_addr,
    output sdram_pkg::sdram_word_t cmd_wdata
);
    import sdram_pkg::*;

    arb_state_t state;
    slot_id_t   owner;      // slot of the command in flight
    logic       grant_ram;
    logic       grant_rom;
    logic       fin;        // done of our own command

    assign grant_ram = (state == IDLE) && ram_req;
    assign grant_rom = (state == IDLE) && !ram_req && rom_req;   // ram first
    assign fin       = done && (state == BUSY);

    // completion goes back only to the owner
    assign ram_din_ok = fin && (owner == SLOT_RAM);
    assign rom_din_ok = fin && (owner == SLOT_ROM);
    assign rdata      = mem_rdata;  // both slots see it, din_ok qualifies

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            owner     <= SLOT_RAM;
            ram_ack   <= 1'b0;
            rom_ack   <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            ram_ack   <= grant_ram;     // single cycle pulses
            rom_ack   <= grant_rom;
            cmd_valid <= grant_ram || grant_rom;
            case (state)
                IDLE: begin
                    if (grant_ram || grant_rom) begin
                        state <= BUSY;
                        owner <= grant_ram ? SLOT_RAM : SLOT_ROM;
                    end
                end
                BUSY: begin
                    if (done) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // command payload, sampled from the winner
    always_ff @(posedge clk) begin
        if (grant_ram) begin
            cmd_we    <= ~ram_rnw;
            cmd_addr  <= ram_addr;
            cmd_wdata <= ram_wdata;
        end else if (grant_rom) begin
            cmd_we    <= 1'b0;      // rom never writes
            cmd_addr  <= rom_addr;
            cmd_wdata <= '0;
        end
    end

    a_one_ack: assert property (@(posedge clk) disable iff (rst)
        !(ram_ack && rom_ack))
        else $error("sdram_arbiter: both slots acked");

    // memory must not finish anything we did not send
    a_done_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> (state == BUSY))
        else $error("sdram_arbiter: done outside BUSY");

endmodule

// ==== hw/rom_rq.sv ====
`timescale 1ns/1ps
`include "sdram_settings.svh"

// read-only client slot
// keeps the last fetched word, both of its halves are served from it
module rom_rq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`ROM_AW-1:0]     addr,       // half-word address
    input  slot_pkg::slot_offset_t offset,
    input  logic                   addr_ok,
    input  logic                   ack,
    input  logic                   din_ok,
    input  sdram_pkg::sdram_word_t din,
    output logic                   req,
    output sdram_pkg::sdram_addr_t sdram_addr,
    output logic                   data_ok,
    output slot_pkg::rom_data_t    dout
);
    import sdram_pkg::*;
    import slot_pkg::*;

    logic        last_ok;
    logic        ok_rise;
    logic        ok_fall;
    sdram_addr_t word_addr;     // addr / 2 + offset
    logic        hit;
    logic        fetching;      // request sent, din_ok not yet back
    logic        cache_valid;
    sdram_addr_t cache_addr;
    sdram_word_t cache_word;
    logic        hi_q;          // half chosen at the start of the access

    function automatic rom_data_t pick_half(input sdram_word_t w, input logic hi);
        pick_half = hi ? w[31:16] : w[15:0];
    endfunction

    assign ok_rise   = addr_ok && !last_ok;
    assign ok_fall   = !addr_ok && last_ok;
    assign word_addr = sdram_addr_t'(addr[`ROM_AW-1:1]) + sdram_addr_t'(offset);
    assign hit       = cache_valid && (cache_addr == word_addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_ok     <= 1'b0;
            req         <= 1'b0;
            data_ok     <= 1'b0;
            fetching    <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            last_ok <= addr_ok;
            if (ok_fall) data_ok <= 1'b0;
            if (ok_rise) begin
                data_ok <= hit;         // cache hit answers right away
                req     <= !hit;
                fetching <= !hit;
            end
            if (ack) req <= 1'b0;
            if (din_ok) begin
                req         <= 1'b0;
                fetching    <= 1'b0;
                data_ok     <= 1'b1;
                cache_valid <= 1'b1;
            end
        end
    end

    // addresses and data, no reset needed
    always_ff @(posedge clk) begin
        if (ok_rise) begin
            hi_q <= addr[0];
            if (hit) dout <= pick_half(cache_word, addr[0]);
            else sdram_addr <= word_addr;
        end
        if (din_ok) begin
            cache_word <= din;
            cache_addr <= sdram_addr;   // tag is the word just fetched
            dout       <= pick_half(din, hi_q);
        end
    end

    // a completion must belong to a fetch of this slot
    a_din_ok_fetch: assert property (@(posedge clk) disable iff (rst)
        din_ok |-> fetching)
        else $error("rom_rq: din_ok without an outstanding fetch");

endmodule

// ==== hw/ram_rq.sv ====
`timescale 1ns/1ps
`include "sdram_settings.svh"

// read/write client slot
// every rising edge of addr_ok gives exactly one memory request
module ram_rq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`RAM_AW-1:0]     addr,
    input  slot_pkg::slot_offset_t offset,
    input  logic                   addr_ok,    // client strobe, toggles per access
    input  logic                   wrin,       // 1 = write
    input  slot_pkg::ram_data_t    wrdata,
    input  logic                   ack,        // arbiter took the request
    input  logic                   din_ok,     // access finished
    input  sdram_pkg::sdram_word_t din,
    output logic                   req,
    output logic                   req_rnw,
    output sdram_pkg::sdram_addr_t sdram_addr,
    output sdram_pkg::sdram_word_t wdata,
    output logic                   data_ok,
    output slot_pkg::ram_data_t    dout
);
    import sdram_pkg::*;

    logic        last_ok;     // addr_ok one cycle ago
    logic        ok_rise;
    logic        ok_fall;
    sdram_addr_t addr_ext;    // client address widened to the channel

    assign ok_rise  = addr_ok && !last_ok;
    assign ok_fall  = !addr_ok && last_ok;
    assign addr_ext = sdram_addr_t'(addr);

    // handshake state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_ok <= 1'b0;
            req     <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            last_ok <= addr_ok;
            if (ok_fall) data_ok <= 1'b0;   // client let go
            if (ok_rise) begin
                req     <= 1'b1;
                data_ok <= 1'b0;
            end
            if (ack) req <= 1'b0;           // granted, stop asking
            if (din_ok) begin
                req     <= 1'b0;
                data_ok <= 1'b1;
            end
        end
    end

    // request payload, held for the whole access
    always_ff @(posedge clk) begin
        if (ok_rise) begin
            req_rnw    <= ~wrin;
            sdram_addr <= addr_ext + sdram_addr_t'(offset);
            wdata      <= sdram_word_t'(wrdata);    // zero extended
        end
        if (din_ok) dout <= din[`RAM_DW-1:0];       // low part of the word
    end

    // the arbiter only answers a live request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        ack |-> req)
        else $error("ram_rq: ack while req is low");

endmodule

// ==== hw/slot_pkg.sv ====
`include "sdram_settings.svh"

// client side of the subsystem: what the cpu / video logic sees
package slot_pkg;

    // base of a slot's region in the memory, in words
    // set once by the system, not during an access
    typedef logic [21:0] slot_offset_t;

    // ram slot data, zero extended to a full word on writes
    typedef logic [`RAM_DW-1:0] ram_data_t;

    // rom slot data, one half of a memory word
    typedef logic [`ROM_DW-1:0] rom_data_t;

endpackage

// ==== hw/sdram_pkg.sv ====
`include "sdram_settings.svh"

// memory side of the subsystem: channel between arbiter and sdram model
package sdram_pkg;

    // word address as a slot puts it on the channel, 4M words max
    typedef logic [21:0] sdram_addr_t;

    // one memory word, slots use its low part on writes
    typedef logic [31:0] sdram_word_t;

    // who owns the channel right now
    typedef logic slot_id_t;

    localparam slot_id_t SLOT_RAM = 1'b0;
    localparam slot_id_t SLOT_ROM = 1'b1;   // lower priority

    // arbiter fsm
    typedef enum logic {
        IDLE,   // waiting for any req
        BUSY    // one command in flight, waiting for done
    } arb_state_t;

endpackage

// ==== hw/sdram_settings.svh ====
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// memory model size, log2 of the depth in 32-bit words
`define MEM_AW 10

// cycles from cmd_valid to done, must be 1 or more
`define MEM_LAT 4

// ram slot: byte wide by default
`define RAM_DW 8
`define RAM_AW 10

// rom slot serves half words out of 32-bit memory words
`define ROM_DW 16
`define ROM_AW 11   // half-word address

`endif
